/* include/bfp_params.svh */
`ifndef BFP_PARAMS_SVH
`define BFP_PARAMS_SVH

// lanes per row as a power of two
`define MAT_SIZE 16

// --------------------
// ieee-754 single precision fields
// --------------------
`define FP_DATA_W 32
`define FP_EXP_W 8
`define FP_MANT_W 23

// --------------------
// quantized lane
// --------------------
// signed with one sign bit
`define Q_W 8

`endif

/* hdl/bfp_pkg.sv */
`default_nettype none

`include "bfp_params.svh"

package bfp_pkg;

    // raw float word and its fields
    typedef logic [`FP_DATA_W-1:0] fp_word_t;
    typedef logic [`FP_EXP_W-1:0] fp_exp_t;
    typedef logic [`FP_MANT_W-1:0] fp_mant_t;

    // one block-floating-point lane in two's complement
    typedef logic signed [`Q_W-1:0] q_word_t;

    // --------------------
    // controller states
    // --------------------
    typedef enum logic [1:0] {
        ST_LOAD,
        ST_CONVERT,
        ST_EMIT
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/row_buffer.sv */
`default_nettype none

`include "bfp_params.svh"

module row_buffer (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               load_en,
    input  wire bfp_pkg::fp_word_t            word,
    output logic [`MAT_SIZE*`FP_DATA_W-1:0]   row_data
);

    import bfp_pkg::*;

    // lane 0 holds the oldest word of the row
    fp_word_t lanes [`MAT_SIZE];

    // --------------------
    // shift register
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MAT_SIZE; i++) begin
                lanes[i] <= '0;
            end
        end else if (load_en) begin
            // everything moves one lane down
            for (int i = 0; i < `MAT_SIZE - 1; i++) begin
                lanes[i] <= lanes[i+1];
            end
            // newest word enters at the top
            lanes[`MAT_SIZE-1] <= word;
        end
    end

    // --------------------
    // pack lanes into the row vector
    // --------------------
    // lane i sits at bit i*FP_DATA_W
    for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_pack
        assign row_data[i*`FP_DATA_W +: `FP_DATA_W] = lanes[i];
    end

endmodule

`default_nettype wire

/* hdl/max_finder.sv */
`default_nettype none

`include "bfp_params.svh"

module max_finder #(
    parameter int MAT_SIZE  = `MAT_SIZE,
    parameter int FP_DATA_W = `FP_DATA_W,
    parameter int FP_EXP_W  = `FP_EXP_W,
    parameter int FP_MANT_W = `FP_MANT_W
) (
    input  wire [MAT_SIZE*FP_DATA_W-1:0]  data,
    output bfp_pkg::fp_exp_t              max_exp,
    output bfp_pkg::fp_mant_t             max_mant
);

    localparam int STAGES = $clog2(MAT_SIZE);
    // every level of the tree stored back to back with the root last
    localparam int NODES = 2 * MAT_SIZE - 1;
    localparam int FIELD_W = FP_EXP_W + FP_MANT_W;

    logic [FP_EXP_W-1:0]  node_exp  [NODES];
    logic [FP_MANT_W-1:0] node_mant [NODES];

    // --------------------
    // 2:1 magnitude compare
    // --------------------
    // exponent first, then hidden bit plus fraction
    // a full tie keeps the lower lane (side a)
    function automatic logic [FIELD_W-1:0] pick(
        input logic [FP_EXP_W-1:0]  exp_a,
        input logic [FP_MANT_W-1:0] mant_a,
        input logic [FP_EXP_W-1:0]  exp_b,
        input logic [FP_MANT_W-1:0] mant_b
    );
        logic [FP_MANT_W:0] sig_a;
        logic [FP_MANT_W:0] sig_b;
        sig_a = {(exp_a != '0), mant_a};
        sig_b = {(exp_b != '0), mant_b};
        if (exp_a > exp_b) begin
            pick = {exp_a, mant_a};
        end else if (exp_b > exp_a) begin
            pick = {exp_b, mant_b};
        end else if (sig_a >= sig_b) begin
            pick = {exp_a, mant_a};
        end else begin
            pick = {exp_b, mant_b};
        end
    endfunction

    // --------------------
    // leaves
    // --------------------
    for (genvar i = 0; i < MAT_SIZE; i++) begin : g_leaf
        logic [FP_DATA_W-1:0] lane;

        assign lane = data[i*FP_DATA_W +: FP_DATA_W];
        // sign bit is simply not looked at
        assign node_exp[i]  = lane[FIELD_W-1 -: FP_EXP_W];
        assign node_mant[i] = lane[FP_MANT_W-1:0];
    end

    // --------------------
    // reduction tree
    // --------------------
    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        // start of this level's inputs and outputs in the node array
        localparam int IN_BASE  = 2 * MAT_SIZE - ((2 * MAT_SIZE) >> s);
        localparam int OUT_BASE = 2 * MAT_SIZE - (MAT_SIZE >> s);
        localparam int N_OUT    = MAT_SIZE >> (s + 1);

        for (genvar p = 0; p < N_OUT; p++) begin : g_pair
            logic [FIELD_W-1:0] win;

            assign win = pick(node_exp[IN_BASE+2*p], node_mant[IN_BASE+2*p],
                              node_exp[IN_BASE+2*p+1], node_mant[IN_BASE+2*p+1]);
            assign node_exp[OUT_BASE+p]  = win[FIELD_W-1 -: FP_EXP_W];
            assign node_mant[OUT_BASE+p] = win[FP_MANT_W-1:0];
        end
    end

    // raw fields of the winning lane
    assign max_exp  = node_exp[NODES-1];
    assign max_mant = node_mant[NODES-1];

endmodule

`default_nettype wire

/* hdl/bfp_converter.sv */
`default_nettype none

`include "bfp_params.svh"

module bfp_converter (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               convert_en,
    input  wire [`MAT_SIZE*`FP_DATA_W-1:0]    row_data,
    input  wire bfp_pkg::fp_exp_t             max_exp,
    input  wire bfp_pkg::fp_mant_t            max_mant,
    output logic [`MAT_SIZE*`Q_W-1:0]         q_data,
    output bfp_pkg::fp_exp_t                  shared_exp,
    output bfp_pkg::fp_mant_t                 shared_mant
);

    import bfp_pkg::*;

    // magnitude bits kept per lane
    localparam int MAG_W = `Q_W - 1;

    logic [`MAT_SIZE*`Q_W-1:0] q_next;

    // --------------------
    // per-lane alignment
    // --------------------
    for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_lane
        fp_word_t             lane_word;
        fp_exp_t              lane_exp;
        logic [`FP_MANT_W:0]  lane_sig;
        logic [MAG_W-1:0]     top_bits;
        fp_exp_t              shift;
        logic [MAG_W-1:0]     mag;
        q_word_t              pos;
        q_word_t              q_lane;

        assign lane_word = row_data[i*`FP_DATA_W +: `FP_DATA_W];
        assign lane_exp  = lane_word[`FP_DATA_W-2 -: `FP_EXP_W];

        // hidden bit is zero for subnormals
        assign lane_sig = {(lane_exp != '0), lane_word[`FP_MANT_W-1:0]};
        assign top_bits = lane_sig[`FP_MANT_W -: MAG_W];

        // max_exp never lies below a lane exponent
        assign shift = max_exp - lane_exp;

        // truncating shift; everything is gone past MAG_W
        assign mag = (shift >= fp_exp_t'(MAG_W)) ? '0 : (top_bits >> shift);

        assign pos    = {1'b0, mag};
        assign q_lane = lane_word[`FP_DATA_W-1] ? -pos : pos;

        assign q_next[i*`Q_W +: `Q_W] = q_lane;
    end

    // --------------------
    // output register
    // --------------------
    // loaded once per row, held through the emit cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            q_data      <= '0;
            shared_exp  <= '0;
            shared_mant <= '0;
        end else if (convert_en) begin
            q_data      <= q_next;
            shared_exp  <= max_exp;
            shared_mant <= max_mant;
        end
    end

endmodule

`default_nettype wire

/* hdl/bfp_ctrl.sv */
`default_nettype none

`include "bfp_params.svh"

module bfp_ctrl (
    input  wire   clk,
    input  wire   reset,
    input  wire   in_valid,
    output logic  load_en,
    output logic  convert_en,
    output logic  busy,
    output logic  out_valid
);

    import bfp_pkg::*;

    localparam int CNT_W = $clog2(`MAT_SIZE);

    ctrl_state_t        state;
    ctrl_state_t        state_next;
    logic [CNT_W-1:0]   word_cnt;
    logic               last_word;

    // --------------------
    // strobes
    // --------------------
    // busy still covers the first load cycle after emit
    assign load_en    = in_valid && (state == ST_LOAD) && !busy;
    assign last_word  = load_en && (word_cnt == CNT_W'(`MAT_SIZE - 1));
    assign convert_en = (state == ST_CONVERT);

    // --------------------
    // next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            ST_LOAD: begin
                if (last_word) begin
                    state_next = ST_CONVERT;
                end
            end
            ST_CONVERT: state_next = ST_EMIT;
            ST_EMIT:    state_next = ST_LOAD;
            default:    state_next = ST_LOAD;
        endcase
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_LOAD;
            word_cnt  <= '0;
            busy      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state <= state_next;
            // wraps back to zero on the last word of a row
            if (load_en) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
            // both flags trail the state by one cycle
            busy      <= (state != ST_LOAD);
            out_valid <= (state == ST_EMIT);
        end
    end

endmodule

`default_nettype wire

/* hdl/bfp_quantizer_top.sv */
`default_nettype none

`include "bfp_params.svh"

module bfp_quantizer_top (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               in_valid,
    input  wire bfp_pkg::fp_word_t            in_data,
    output logic                              busy,
    output logic                              out_valid,
    output bfp_pkg::fp_exp_t                  out_exp,
    output bfp_pkg::fp_mant_t                 out_max_mant,
    output logic [`MAT_SIZE*`Q_W-1:0]         out_data
);

    import bfp_pkg::*;

    logic                              load_en;
    logic                              convert_en;
    logic [`MAT_SIZE*`FP_DATA_W-1:0]   row_data;
    fp_exp_t                           max_exp;
    fp_mant_t                          max_mant;

    // --------------------
    // sequencing
    // --------------------
    bfp_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .load_en    (load_en),
        .convert_en (convert_en),
        .busy       (busy),
        .out_valid  (out_valid)
    );

    // --------------------
    // datapath
    // --------------------
    row_buffer u_row_buffer (
        .clk      (clk),
        .reset    (reset),
        .load_en  (load_en),
        .word     (in_data),
        .row_data (row_data)
    );

    // shared exponent search
    max_finder #(
        .MAT_SIZE  (`MAT_SIZE),
        .FP_DATA_W (`FP_DATA_W),
        .FP_EXP_W  (`FP_EXP_W),
        .FP_MANT_W (`FP_MANT_W)
    ) u_max_finder (
        .data     (row_data),
        .max_exp  (max_exp),
        .max_mant (max_mant)
    );

    bfp_converter u_converter (
        .clk         (clk),
        .reset       (reset),
        .convert_en  (convert_en),
        .row_data    (row_data),
        .max_exp     (max_exp),
        .max_mant    (max_mant),
        .q_data      (out_data),
        .shared_exp  (out_exp),
        .shared_mant (out_max_mant)
    );

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
`default_nettype none

module clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // free running and starting low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_bfp_quantizer.sv */
`default_nettype none

`include "bfp_params.svh"

module tb_bfp_quantizer;

    import bfp_pkg::*;

    localparam int NUM_BASE   = 6;
    localparam int NUM_JUNK   = 3;
    localparam int NUM_ROWS   = NUM_BASE + NUM_JUNK;
    localparam int TOTAL_ROWS = 2 * NUM_BASE + NUM_JUNK;
    localparam int MAX_GAP    = 3;
    localparam int IDLE       = 1000;
    // worst case row has the full gap before every word and 4 cycles to emit
    localparam int ROW_CYCLES = `MAT_SIZE * (MAX_GAP + 1) + 4;
    localparam longint TIMEOUT = (longint'(TOTAL_ROWS) * ROW_CYCLES + 60) * 100;

    logic                         clk;
    logic                         reset;
    logic                         in_valid;
    fp_word_t                     in_data;
    logic                         busy;
    logic                         out_valid;
    fp_exp_t                      out_exp;
    fp_mant_t                     out_max_mant;
    logic [`MAT_SIZE*`Q_W-1:0]    out_data;

    integer seed = 50;
    fp_word_t rows [NUM_ROWS][`MAT_SIZE];

    // expected rows with the oldest first
    fp_exp_t                      want_exp [$];
    fp_mant_t                     want_mant [$];
    logic [`MAT_SIZE*`Q_W-1:0]    want_data [$];
    // captured rows for comparing gapped and back-to-back runs
    logic [`MAT_SIZE*`Q_W-1:0]    got_data [$];
    fp_exp_t                      got_exp [$];

    // cycles since the last word of a row was sampled
    int  since_last = IDLE;
    bit  last_pending = 1'b0;

    clk_gen #(.PERIOD(100)) u_clk_gen (.clk(clk));

    bfp_quantizer_top DUT (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .busy         (busy),
        .out_valid    (out_valid),
        .out_exp      (out_exp),
        .out_max_mant (out_max_mant),
        .out_data     (out_data)
    );

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int rand_range(input int lo, input int span);
        rand_range = lo + int'($unsigned($random(seed)) % span);
    endfunction

    function automatic fp_word_t make_word(input logic s, input int e, input fp_mant_t f);
        make_word = {s, fp_exp_t'(e), f};
    endfunction

    function automatic fp_exp_t exp_of(input fp_word_t w);
        exp_of = w[`FP_DATA_W-2 -: `FP_EXP_W];
    endfunction

    // hidden bit joined to the fraction
    function automatic logic [`FP_MANT_W:0] sig_of(input fp_word_t w);
        sig_of = {(exp_of(w) != 0), w[`FP_MANT_W-1:0]};
    endfunction

    // --------------------
    // reference model
    // --------------------
    task automatic predict_row(input int idx);
        int                          best;
        fp_exp_t                     e_max;
        int                          shift;
        int                          mag;
        int                          q;
        logic [`MAT_SIZE*`Q_W-1:0]   packed_q;
        best = 0;
        for (int i = 1; i < `MAT_SIZE; i++) begin
            if (exp_of(rows[idx][i]) > exp_of(rows[idx][best])) begin
                best = i;
            end else if (exp_of(rows[idx][i]) == exp_of(rows[idx][best]) &&
                         sig_of(rows[idx][i]) > sig_of(rows[idx][best])) begin
                best = i;
            end
        end
        e_max = exp_of(rows[idx][best]);
        for (int i = 0; i < `MAT_SIZE; i++) begin
            shift = int'(e_max) - int'(exp_of(rows[idx][i]));
            // keep the top 7 significand bits, then truncate on the shift
            mag = int'(sig_of(rows[idx][i]) >> (`FP_MANT_W + 2 - `Q_W));
            mag = (shift >= `Q_W - 1) ? 0 : (mag >> shift);
            q = rows[idx][i][`FP_DATA_W-1] ? -mag : mag;
            packed_q[i*`Q_W +: `Q_W] = q[`Q_W-1:0];
        end
        want_exp.push_back(e_max);
        want_mant.push_back(rows[idx][best][`FP_MANT_W-1:0]);
        want_data.push_back(packed_q);
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic build_rows();
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < `MAT_SIZE; i++) begin
                rows[r][i] = make_word($random(seed), rand_range(120, 11), $random(seed));
            end
        end
        // largest magnitude lane is negative
        rows[1][5] = make_word(1'b1, 140, $random(seed));
        for (int i = 0; i < `MAT_SIZE; i++) begin
            rows[2][i] = '0;
            rows[3][i] = make_word($random(seed), 0, $random(seed));
            rows[4][i] = make_word($random(seed), 127, $random(seed));
            rows[5][i] = make_word($random(seed), rand_range(100, 41), $random(seed));
        end
        // ties on the top exponent with lanes 7 and 9 tied fully on magnitude
        rows[4][3]  = make_word(1'b0, 130, 23'h2aaaaa);
        rows[4][7]  = make_word(1'b1, 130, 23'h6abcde);
        rows[4][9]  = make_word(1'b0, 130, 23'h6abcde);
        rows[4][12] = make_word(1'b1, 130, 23'h000001);
        // shifts of 30, 7 and 6
        rows[4][0]  = make_word(1'b0, 100, 23'h7fffff);
        rows[4][2]  = make_word(1'b1, 123, 23'h7fffff);
        rows[4][5]  = make_word(1'b1, 124, 23'h7fffff);
    endtask

    // starts and ends on a falling edge
    task automatic send_row(input int idx, input int max_gap, input bit junk);
        int gap;
        predict_row(idx);
        for (int i = 0; i < `MAT_SIZE; i++) begin
            gap = (max_gap > 0) ? rand_range(0, max_gap + 1) : 0;
            repeat (gap) @(negedge clk);
            in_valid = 1'b1;
            in_data  = rows[idx][i];
            if (i == `MAT_SIZE - 1) begin
                last_pending = 1'b1;
            end
            @(negedge clk);
            in_valid = 1'b0;
        end
        while (!busy) begin
            @(negedge clk);
        end
        // words offered here must not reach the next row
        while (busy) begin
            if (junk) begin
                in_valid = 1'b1;
                in_data  = $random(seed);
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    // --------------------
    // checking
    // --------------------
    task automatic check_row();
        logic [`MAT_SIZE*`Q_W-1:0]   e_data;
        q_word_t                     got_q;
        q_word_t                     exp_q;
        bit                          big_found;
        assert (want_exp.size() > 0) else report_failure("output row with no row sent");
        e_data = want_data.pop_front();
        assert (out_exp == want_exp[0]) else report_failure(
            $sformatf("out_exp got %0d expected %0d", out_exp, want_exp[0]));
        assert (out_max_mant == want_mant[0]) else report_failure(
            $sformatf("out_max_mant got %h expected %h", out_max_mant, want_mant[0]));
        void'(want_exp.pop_front());
        void'(want_mant.pop_front());
        big_found = 1'b0;
        for (int i = 0; i < `MAT_SIZE; i++) begin
            got_q = out_data[i*`Q_W +: `Q_W];
            exp_q = e_data[i*`Q_W +: `Q_W];
            assert (got_q == exp_q) else report_failure(
                $sformatf("lane %0d got %0d expected %0d", i, got_q, exp_q));
            if (got_q >= 64 || got_q <= -64) begin
                big_found = 1'b1;
            end
        end
        // a normal max lane keeps its hidden bit in the top position
        assert (out_exp == 0 || big_found) else report_failure("no lane reaches magnitude 64");
        got_data.push_back(out_data);
        got_exp.push_back(out_exp);
    endtask

    always @(posedge clk) begin
        if (last_pending) begin
            since_last = 0;
            last_pending = 1'b0;
        end else if (since_last < IDLE) begin
            since_last = since_last + 1;
        end
    end

    always @(negedge clk) begin : output_check
        bit want_busy;
        bit want_valid;
        // busy is high after edges N+1 and N+2 and falls after edge N+3
        want_busy  = (since_last >= 1 && since_last <= 2);
        want_valid = (since_last == 2);
        assert (busy === want_busy) else report_failure(
            $sformatf("busy is %b, expected %b", busy, want_busy));
        assert (out_valid === want_valid) else report_failure(
            $sformatf("out_valid is %b, expected %b", out_valid, want_valid));
        if (out_valid === 1'b1) begin
            check_row();
        end
    end

    // watchdog
    initial begin
        #(TIMEOUT);
        $display("watchdog expired before all rows came out of the DUT");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        reset    = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        build_rows();
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // back to back
        for (int r = 0; r < NUM_BASE; r++) begin
            send_row(r, 0, 1'b0);
        end
        // same rows with gaps between words
        for (int r = 0; r < NUM_BASE; r++) begin
            send_row(r, MAX_GAP, 1'b0);
        end
        // stray words while busy
        for (int r = NUM_BASE; r < NUM_ROWS; r++) begin
            send_row(r, 1, 1'b1);
        end

        repeat (4) @(negedge clk);
        assert (want_exp.size() == 0) else report_failure("rows sent but never emitted");
        assert (got_data.size() == TOTAL_ROWS) else report_failure("wrong number of output rows");
        for (int r = 0; r < NUM_BASE; r++) begin
            assert (got_data[r] == got_data[r+NUM_BASE] && got_exp[r] == got_exp[r+NUM_BASE])
            else report_failure($sformatf("row %0d differs when sent with gaps", r));
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hdl/bfp_pkg.sv
hdl/row_buffer.sv
hdl/max_finder.sv
hdl/bfp_converter.sv
hdl/bfp_ctrl.sv
hdl/bfp_quantizer_top.sv
verif/clk_gen.sv
verif/tb_bfp_quantizer.sv
